/* vlog.f */
design/byte_stream_pkg.sv
design/uart_pkg.sv
design/fifo_wr_if.sv
design/fifo_rd_if.sv
design/byte_intake.sv
design/sync_fifo.sv
design/uart_tx_serializer.sv
design/byte_tx_top.sv
tb/tb_byte_tx_top.sv

/* tb/tb_byte_tx_top.sv */
`timescale 1ns/1ps

module tb_byte_tx_top;
    import byte_stream_pkg::*;

    localparam int DEPTH          = 16;
    localparam int AF_LEVEL       = 12;
    localparam int AE_LEVEL       = 2;
    localparam int CLKS_PER_BIT   = 4;
    localparam int CLK_NS         = 8;
    localparam int BIT_NS         = CLKS_PER_BIT * CLK_NS;
    localparam int FRAME_BITS     = 10;   // Start, 8 data, stop
    localparam int TIMEOUT_CYCLES = 6000; // About 70 bytes at 42 cycles plus margin

    logic      clk;
    logic      rst;
    logic      in_valid;
    byte_t     in_data;
    logic      tx;
    logic      full;
    logic      almost_full;
    logic      empty;
    logic      almost_empty;
    drop_cnt_t drop_count;

    byte_t            exp_q[$];    // Accepted bytes, oldest first
    logic [9:0]       rx_q[$];     // Frames seen on the line
    drop_cnt_t        exp_drops;   // Model drop counter
    int               accepted;    // Bytes the model let in
    int               rx_count;    // Frames compared so far
    int               cycles;      // Timeout counter
    bit               saw_full;    // full seen during the burst
    integer           seed;
    string            test_name;
    logic [9:0]       mon_frame;
    int               mon_idx;

    byte_tx_top #(
        .DEPTH        (DEPTH),
        .AF_LEVEL     (AF_LEVEL),
        .AE_LEVEL     (AE_LEVEL),
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) UUT (
        .clk          (clk),
        .rst          (rst),
        .in_valid     (in_valid),
        .in_data      (in_data),
        .tx           (tx),
        .full         (full),
        .almost_full  (almost_full),
        .empty        (empty),
        .almost_empty (almost_empty),
        .drop_count   (drop_count)
    );

    // Expected line bits for one byte with index 0 sent first
    function automatic logic [9:0] uart_frame(input byte_t b);
        return {1'b1, b, 1'b0}; // Stop, data LSB first, start
    endfunction

    // Saturating drop count of the intake
    function automatic drop_cnt_t next_drop_count(input drop_cnt_t cnt);
        return (cnt == '1) ? cnt : cnt + 1'b1;
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("ERR %s expected %0h actual %0h", name, exp, act);
            fail_run("value mismatch");
        end
    endtask

    // Offer one byte for one cycle while the model judges it by full
    task automatic send_byte(input byte_t b);
        in_valid = 1'b1;
        in_data  = b;
        if (full) begin
            exp_drops = next_drop_count(exp_drops);
            saw_full  = 1'b1;
        end else begin
            exp_q.push_back(b);
            accepted++;
        end
        @(posedge clk);
        #1;
        in_valid = 1'b0;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    // Until every accepted byte came back off the line
    task automatic wait_drained();
        while (rx_count < accepted) begin
            @(posedge clk);
            #1;
        end
    endtask

    // Line held high for a few bit periods
    task automatic wait_line_idle();
        int high_cycles;
        high_cycles = 0;
        while (high_cycles < 3 * CLKS_PER_BIT) begin
            @(posedge clk);
            #1;
            high_cycles = tx ? high_cycles + 1 : 0;
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) fail_run("Timeout, the tests did not finish in time");
    end

    // Flag relations sampled mid-cycle
    always @(negedge clk) begin
        if (rst) begin
            check("full_implies_almost_full", 1, !full || almost_full);
            check("empty_implies_almost_empty", 1, !empty || almost_empty);
            check("full_and_empty_exclusive", 0, full && empty);
        end
    end

    // Line monitor sampling mid-bit after each start edge
    initial begin
        @(posedge rst);
        forever begin
            @(negedge tx);
            #(BIT_NS / 2);
            for (mon_idx = 0; mon_idx < FRAME_BITS; mon_idx++) begin
                mon_frame[mon_idx] = tx;
                if (mon_idx < FRAME_BITS - 1) #(BIT_NS);
            end
            if (mon_frame[FRAME_BITS-1] !== 1'b1) fail_run("Stop bit on tx was not high");
            else rx_q.push_back(mon_frame);
        end
    end

    // Compare each received frame with the oldest accepted byte
    initial begin
        forever begin
            while (rx_q.size() == 0) @(posedge clk);
            if (exp_q.size() == 0) begin
                fail_run("Frame on tx while no byte was expected");
            end else begin
                check(test_name, uart_frame(exp_q.pop_front()), rx_q.pop_front());
                rx_count++;
            end
        end
    end

    initial begin
        rst       = 1'b0;
        in_valid  = 1'b0;
        in_data   = '0;
        cycles    = 0;
        exp_drops = '0;
        accepted  = 0;
        rx_count  = 0;
        saw_full  = 1'b0;
        seed      = 32'he93f_19b1;
        test_name = "reset";

        repeat (4) @(posedge clk);
        #1;
        rst = 1'b1;

        // Reset state
        check("reset_tx", 1, tx);
        check("reset_empty", 1, empty);
        check("reset_almost_empty", 1, almost_empty);
        check("reset_full", 0, full);
        check("reset_almost_full", 0, almost_full);
        check("reset_drop_count", 0, drop_count);
        idle_cycles(5);

        // Lone bytes with each one fully sent before the next
        test_name = "single_bytes";
        send_byte(8'h00);
        wait_drained();
        idle_cycles(20);
        send_byte(8'hFF);
        wait_drained();
        idle_cycles(20);
        send_byte(8'hA5);
        wait_drained();
        idle_cycles(20);

        // Back-to-back burst that overruns the FIFO
        test_name = "burst";
        repeat (40) send_byte(byte_t'($random(seed)));
        wait_drained();
        check("burst_saw_full", 1, saw_full);
        check("burst_drop_count", exp_drops, drop_count);

        // Random bytes with random gaps
        test_name = "random";
        repeat (25) begin
            send_byte(byte_t'($random(seed)));
            idle_cycles({$random(seed)} % 61);
        end
        wait_drained();
        wait_line_idle();
        check("final_empty", 1, empty);
        check("final_almost_empty", 1, almost_empty);
        check("final_drop_count", exp_drops, drop_count);

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

/* design/byte_tx_top.sv */
`timescale 1ns/1ps

// Byte transmit buffer, intake, FIFO and UART serializer
module byte_tx_top #(
    parameter int DEPTH        = 16, // FIFO entries
    parameter int AF_LEVEL     = 12, // almost_full threshold
    parameter int AE_LEVEL     = 2,  // almost_empty threshold
    parameter int CLKS_PER_BIT = 4   // UART bit period in clocks
) (
    input  logic                       clk,
    input  logic                       rst,          // Active low, synchronous
    input  logic                       in_valid,     // Byte strobe
    input  byte_stream_pkg::byte_t     in_data,
    output logic                       tx,           // UART line
    output logic                       full,
    output logic                       almost_full,
    output logic                       empty,
    output logic                       almost_empty,
    output byte_stream_pkg::drop_cnt_t drop_count    // Overflow bytes
);

    fifo_wr_if wr_bus (); // Intake to FIFO
    fifo_rd_if rd_bus (); // FIFO to serializer

    byte_intake u_intake (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_data    (in_data),
        .wr         (wr_bus.src),
        .drop_count (drop_count)
    );

    sync_fifo #(
        .DEPTH    (DEPTH),
        .AF_LEVEL (AF_LEVEL),
        .AE_LEVEL (AE_LEVEL)
    ) u_fifo (
        .clk (clk),
        .rst (rst),
        .wr  (wr_bus.sink),
        .rd  (rd_bus.src)
    );

    uart_tx_serializer #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) u_serializer (
        .clk (clk),
        .rst (rst),
        .rd  (rd_bus.sink),
        .tx  (tx)
    );

    // Status flags out to pins
    assign full         = wr_bus.full;
    assign almost_full  = wr_bus.almost_full;
    assign empty        = rd_bus.empty;
    assign almost_empty = rd_bus.almost_empty;

endmodule

/* design/uart_tx_serializer.sv */
`timescale 1ns/1ps

// Drains the FIFO one byte at a time into 8N1 UART frames
module uart_tx_serializer #(
    parameter int CLKS_PER_BIT = 4 // Clock cycles per line bit
) (
    input  logic clk,
    input  logic rst, // Active low, synchronous
    fifo_rd_if.sink rd,
    output logic tx   // Serial line, idles high
);
    import byte_stream_pkg::*;
    import uart_pkg::*;

    localparam int CNT_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;

    typedef logic [CNT_W-1:0] cnt_t;

    localparam cnt_t LAST_CNT = cnt_t'(CLKS_PER_BIT - 1);

    tx_state_t state;
    tx_state_t state_nxt;
    cnt_t      clk_cnt;  // Cycles spent in the current bit
    bit_idx_t  bit_idx;  // Data bit on the line
    byte_t     shift_q;  // Frame payload, LSB goes out first
    logic      bit_end;  // Last cycle of a bit period

    assign bit_end = (clk_cnt == LAST_CNT);

    // Pop while idle and data waits, byte lands in FETCH
    assign rd.pop = (state == IDLE) && !rd.empty;

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE:  if (!rd.empty) state_nxt = FETCH;
            FETCH: state_nxt = START; // Read data valid this cycle
            START: if (bit_end) state_nxt = DATA;
            DATA:  if (bit_end && bit_idx == LAST_BIT_IDX) state_nxt = STOP;
            STOP:  if (bit_end) state_nxt = IDLE;
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // Bit period timer, runs only inside the frame
    always_ff @(posedge clk) begin
        if (!rst) begin
            clk_cnt <= '0;
        end else if (state == START || state == DATA || state == STOP) begin
            clk_cnt <= bit_end ? '0 : clk_cnt + 1'b1;
        end else begin
            clk_cnt <= '0;
        end
    end

    // Data bit index
    always_ff @(posedge clk) begin
        if (!rst) begin
            bit_idx <= '0;
        end else if (state == DATA) begin
            if (bit_end) begin
                bit_idx <= bit_idx + 1'b1; // Wraps to 0 after the last bit
            end
        end else begin
            bit_idx <= '0;
        end
    end

    // Payload shift register
    always_ff @(posedge clk) begin
        if (state == FETCH) begin
            shift_q <= rd.data;                // Latch popped byte
        end else if (state == DATA && bit_end) begin
            shift_q <= {1'b0, shift_q[BYTE_W-1:1]}; // Next bit to LSB
        end
    end

    // Line level by state
    always_comb begin
        case (state)
            START:   tx = 1'b0;
            DATA:    tx = shift_q[0];
            default: tx = 1'b1; // IDLE, FETCH and STOP
        endcase
    end

endmodule

/* design/sync_fifo.sv */
`timescale 1ns/1ps

// Single-clock RAM FIFO with level-based flags
module sync_fifo #(
    parameter int DEPTH    = 16, // Entries
    parameter int AF_LEVEL = 12, // almost_full at or above this level
    parameter int AE_LEVEL = 2   // almost_empty at or below this level
) (
    input  logic clk,
    input  logic rst,  // Active low, synchronous
    fifo_wr_if.sink wr,
    fifo_rd_if.src  rd
);
    import byte_stream_pkg::*;

    localparam int ADDR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [ADDR_W:0]   level_t; // One bit wider, holds DEPTH itself

    localparam addr_t  LAST_ADDR = addr_t'(DEPTH - 1);
    localparam level_t FULL_LVL  = level_t'(DEPTH);
    localparam level_t AF_LVL    = level_t'(AF_LEVEL);
    localparam level_t AE_LVL    = level_t'(AE_LEVEL);

    byte_t  mem [DEPTH];   // Storage, inferred as block RAM
    byte_t  rd_data_q;     // Registered read port
    addr_t  wr_addr;
    addr_t  rd_addr;
    level_t level;         // Entries currently held
    logic   pop_ok;        // Pop that actually removes an entry

    // Empty pop ignored, write side trusts the intake
    assign pop_ok = rd.pop && !rd.empty;

    // Write port, no full check here
    always_ff @(posedge clk) begin
        if (wr.push) begin
            mem[wr_addr] <= wr.data;
        end
    end

    // Read port on the rising edge, held until the next pop
    always_ff @(posedge clk) begin
        if (pop_ok) begin
            rd_data_q <= mem[rd_addr];
        end
    end

    // Addresses wrap at DEPTH, also for non power of two depths
    always_ff @(posedge clk) begin
        if (!rst) begin
            wr_addr <= '0;
            rd_addr <= '0;
        end else begin
            if (wr.push) begin
                wr_addr <= (wr_addr == LAST_ADDR) ? '0 : wr_addr + 1'b1;
            end
            if (pop_ok) begin
                rd_addr <= (rd_addr == LAST_ADDR) ? '0 : rd_addr + 1'b1;
            end
        end
    end

    // Fill level, unchanged on simultaneous push and pop
    always_ff @(posedge clk) begin
        if (!rst) begin
            level <= '0;
        end else begin
            case ({wr.push, pop_ok})
                2'b10:   level <= level + 1'b1;
                2'b01:   level <= level - 1'b1;
                default: level <= level;
            endcase
        end
    end

    // Flags straight from the level
    assign wr.full         = (level == FULL_LVL);
    assign wr.almost_full  = (level >= AF_LVL);
    assign rd.empty        = (level == '0);
    assign rd.almost_empty = (level <= AE_LVL);

    assign rd.data = rd_data_q;

endmodule

/* design/byte_intake.sv */
`timescale 1ns/1ps

// Admits bytes while the FIFO has room, counts the rest
module byte_intake (
    input  logic                       clk,
    input  logic                       rst,        // Active low, synchronous
    input  logic                       in_valid,   // Byte strobe from the source
    input  byte_stream_pkg::byte_t     in_data,
    fifo_wr_if.src                     wr,
    output byte_stream_pkg::drop_cnt_t drop_count  // Bytes lost to overflow
);
    import byte_stream_pkg::*;

    logic accept; // Byte goes into the FIFO this cycle
    logic reject; // Byte offered against a full FIFO
    logic at_max; // Counter pinned at its top

    // Only write-side full check in the design
    assign accept = in_valid && !wr.full;
    assign reject = in_valid && wr.full;

    // Same-cycle forward, FIFO level follows on the next edge
    assign wr.push = accept;
    assign wr.data = in_data; // Sampled by the FIFO only on push

    assign at_max = (drop_count == DROP_CNT_MAX);

    // Saturating drop counter
    always_ff @(posedge clk) begin
        if (!rst) begin
            drop_count <= '0;
        end else if (reject && !at_max) begin
            drop_count <= drop_count + 1'b1; // One more lost byte
        end
    end

endmodule

/* design/fifo_rd_if.sv */
`timescale 1ns/1ps

// Read side of the FIFO, FIFO to serializer
interface fifo_rd_if;
    import byte_stream_pkg::*;

    logic  pop;          // One-cycle read strobe
    byte_t data;         // Registered read byte, valid a cycle after pop
    logic  empty;        // Nothing stored
    logic  almost_empty; // Level at or below threshold

    // FIFO side
    modport src (input pop, output data, output empty, output almost_empty);

    // Serializer side
    modport sink (output pop, input data, input empty, input almost_empty);

endinterface

/* design/fifo_wr_if.sv */
`timescale 1ns/1ps

// Write side of the FIFO, intake to FIFO
interface fifo_wr_if;
    import byte_stream_pkg::*;

    byte_t data;       // Byte to store
    logic  push;       // One-cycle write strobe
    logic  full;       // No room left
    logic  almost_full; // Level at or above threshold

    // Intake side
    modport src (output data, output push, input full, input almost_full);

    // FIFO side
    modport sink (input data, input push, output full, output almost_full);

endinterface

/* design/uart_pkg.sv */
// Frame layout and FSM encoding of the UART transmitter
package uart_pkg;

    // Data bits per frame, sent LSB first
    localparam int DATA_BITS = 8;

    // Index of one data bit within the frame
    typedef logic [$clog2(DATA_BITS)-1:0] bit_idx_t;

    // Last data bit before the stop bit
    localparam bit_idx_t LAST_BIT_IDX = bit_idx_t'(DATA_BITS - 1);

    // Serializer FSM states
    typedef enum logic [2:0] {
        IDLE,  // Line high, waiting for data
        FETCH, // Popped byte arrives from the RAM
        START, // Start bit, line low
        DATA,  // Data bits
        STOP   // Stop bit, line high
    } tx_state_t;

endpackage

/* design/byte_stream_pkg.sv */
// Types shared along the byte path, intake to FIFO to serializer
package byte_stream_pkg;

    // Payload width of one link byte
    localparam int BYTE_W = 8;

    // Width of the overflow counter
    localparam int DROP_CNT_W = 16;

    // One data byte as it moves through the buffer
    typedef logic [BYTE_W-1:0] byte_t;

    // Saturating count of bytes lost to a full FIFO
    typedef logic [DROP_CNT_W-1:0] drop_cnt_t;

    // Saturation point of the drop counter
    localparam drop_cnt_t DROP_CNT_MAX = '1;

    // Fill levels depend on DEPTH and are typed inside the FIFO

endpackage
